// File: include/lock_defs.svh
`ifndef LOCK_DEFS_SVH
`define LOCK_DEFS_SVH

// datapath widths
`define W_ADC 18 // adc sample
`define W_EP 16 // loop parameter word
`define W_SUM 64 // pid sum, wide to keep clear of overflow
`define W_DAC 16 // dac word

// loop timing and scaling
`define OVERSAMPLE_LOG 2 // 4 samples per average
`define COMP_LATENCY 1 // cycles in compute
`define OUT_SHIFT 4 // sum to dac right shift
`define DAC_CREDITS 2 // credits held after reset

// bank values after reset
`define SETPOINT_INIT 0
`define P_COEF_INIT 10
`define I_COEF_INIT 3
`define D_COEF_INIT 0

`endif

// File: source/lock_pkg.sv
package lock_pkg;

	////////////////////////////////////////////////////////////////////////////
	// pid core states
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		st_idle = 2'd0, // wait for an averaged sample
		st_compute = 2'd1, // form the new sum
		st_send = 2'd2, // hold sum until downstream ready
		st_writeback = 2'd3 // update error history and sum
	} pid_state_e;

	////////////////////////////////////////////////////////////////////////////
	// parameter bank addresses
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		addr_setpoint = 2'd0, // lock setpoint
		addr_p = 2'd1, // proportional
		addr_i = 2'd2, // integral
		addr_d = 2'd3 // derivative
	} param_addr_e;

endpackage

// File: source/oversample_filter.sv
`timescale 1ns/1ps
`include "lock_defs.svh"

module oversample_filter (
	input logic clk_in,
	input logic reset_in,
	input logic signed [`W_ADC-1:0] adc_data, // raw sample
	input logic adc_valid, // one sample per pulse
	output logic signed [`W_ADC-1:0] avg_data, // group average
	output logic avg_valid // one cycle pulse
);

	localparam int W_ACC = `W_ADC + `OVERSAMPLE_LOG; // room for the full group
	localparam int W_CNT = (`OVERSAMPLE_LOG > 0) ? `OVERSAMPLE_LOG : 1;

	logic signed [W_ACC-1:0] acc; // running group sum
	logic signed [W_ACC-1:0] acc_next; // sum including this sample
	logic signed [W_ACC-1:0] acc_shifted; // group sum over ratio
	logic [W_CNT-1:0] cnt; // samples taken so far
	logic last; // this sample closes the group

	assign acc_next = acc + W_ACC'(adc_data); // sign extended add
	assign acc_shifted = acc_next >>> `OVERSAMPLE_LOG; // floor, as a shift does
	assign last = (cnt == W_CNT'((1 << `OVERSAMPLE_LOG) - 1));

	// accumulator and sample count
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			acc <= '0;
			cnt <= '0;
		end else if (adc_valid) begin
			if (last) begin
				acc <= '0; // start next group
				cnt <= '0;
			end else begin
				acc <= acc_next;
				cnt <= cnt + 1'b1;
			end
		end
	end

	// average out, fits back into sample width
	always_ff @(posedge clk_in) begin
		if (adc_valid && last) begin
			avg_data <= acc_shifted[`W_ADC-1:0];
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			avg_valid <= 1'b0;
		end else begin
			avg_valid <= adc_valid && last; // one cycle after last sample
		end
	end

endmodule

// File: source/pid_param_bank.sv
`timescale 1ns/1ps
`include "lock_defs.svh"

module pid_param_bank (
	input logic clk_in,
	input logic reset_in,
	input logic cfg_write, // write strobe
	input lock_pkg::param_addr_e cfg_addr, // register select
	input logic signed [`W_EP-1:0] cfg_data, // write value
	input logic update_en, // writes ignored when low
	output logic signed [`W_EP-1:0] setpoint,
	output logic signed [`W_EP-1:0] p_coef,
	output logic signed [`W_EP-1:0] i_coef,
	output logic signed [`W_EP-1:0] d_coef
);

	import lock_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// loop parameter registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			setpoint <= `W_EP'(`SETPOINT_INIT);
			p_coef <= `W_EP'(`P_COEF_INIT);
			i_coef <= `W_EP'(`I_COEF_INIT);
			d_coef <= `W_EP'(`D_COEF_INIT);
		end else if (cfg_write && update_en) begin
			// takes effect on the next clock
			case (cfg_addr)
				addr_setpoint: setpoint <= cfg_data;
				addr_p: p_coef <= cfg_data;
				addr_i: i_coef <= cfg_data;
				addr_d: d_coef <= cfg_data;
				default: ; // all four codes used
			endcase
		end
	end

endmodule

// File: source/pid_core.sv
`timescale 1ns/1ps
`include "lock_defs.svh"

module pid_core (
	input logic clk_in,
	input logic reset_in,
	input logic lock_en, // low clears loop history
	input logic signed [`W_ADC-1:0] avg_data, // averaged sample
	input logic avg_valid, // taken only in idle
	input logic signed [`W_EP-1:0] setpoint,
	input logic signed [`W_EP-1:0] p_coef,
	input logic signed [`W_EP-1:0] i_coef,
	input logic signed [`W_EP-1:0] d_coef,
	input logic out_ready, // output stage has a credit
	output logic signed [`W_SUM-1:0] pid_data, // control sum
	output logic pid_valid // held in send
);

	import lock_pkg::*;

	localparam int W_E = `W_ADC + 1; // error, one bit over sample
	localparam int W_K = `W_EP + 2; // coefficient sums
	localparam int W_CNT = $clog2(`COMP_LATENCY + 1);
	localparam logic signed [`W_SUM-1:0] SUM_MAX = {1'b0, {(`W_SUM-1){1'b1}}};
	localparam logic signed [`W_SUM-1:0] SUM_MIN = {1'b1, {(`W_SUM-1){1'b0}}};

	pid_state_e state_q; // current state
	pid_state_e state_d; // next state
	logic [W_CNT-1:0] cnt; // cycles spent in compute

	logic signed [`W_ADC-1:0] data; // latched sample
	logic signed [W_E-1:0] e_cur; // error now
	logic signed [W_E-1:0] e_prev_0; // error one sample back
	logic signed [W_E-1:0] e_prev_1; // error two samples back
	logic signed [W_E-1:0] e_q; // error that goes with sum_q

	logic signed [W_K-1:0] k1, k2, k3; // velocity form coefficients
	logic signed [`W_SUM-1:0] delta_u; // sum increment
	logic signed [`W_SUM-1:0] u_prev; // last sum sent
	logic signed [`W_SUM-1:0] u_cur; // unrailed new sum
	logic signed [`W_SUM-1:0] u_rail; // new sum after overflow check
	logic signed [`W_SUM-1:0] sum_q; // sum held for send
	logic overflow;
	logic compute_done; // last compute cycle

	////////////////////////////////////////////////////////////////////////////
	// datapath
	////////////////////////////////////////////////////////////////////////////

	assign e_cur = W_E'(setpoint) - W_E'(data);

	assign k1 = W_K'(p_coef) + W_K'(i_coef) + W_K'(d_coef);
	assign k2 = -W_K'(p_coef) - (W_K'(d_coef) <<< 1); // -p - 2d
	assign k3 = W_K'(d_coef);

	assign delta_u = `W_SUM'(k1) * `W_SUM'(e_cur)
		+ `W_SUM'(k2) * `W_SUM'(e_prev_0)
		+ `W_SUM'(k3) * `W_SUM'(e_prev_1);
	assign u_cur = u_prev + delta_u;

	// same sign operands giving opposite sign result
	assign overflow = (delta_u[`W_SUM-1] == u_prev[`W_SUM-1])
		&& (u_cur[`W_SUM-1] != u_prev[`W_SUM-1]);
	assign u_rail = overflow ? (u_prev[`W_SUM-1] ? SUM_MIN : SUM_MAX) : u_cur;

	assign pid_data = sum_q;
	assign pid_valid = (state_q == st_send);

	// sample latch, cleared while unlocked
	always_ff @(posedge clk_in) begin
		if (reset_in || !lock_en) begin
			data <= '0;
		end else if (avg_valid && state_q == st_idle) begin
			data <= avg_data;
		end
	end

	// snapshot so the sum stays put while send waits
	always_ff @(posedge clk_in) begin
		if (compute_done) begin
			sum_q <= u_rail;
			e_q <= e_cur;
		end
	end

	// loop history
	always_ff @(posedge clk_in) begin
		if (reset_in || !lock_en) begin
			u_prev <= '0;
			e_prev_0 <= '0;
			e_prev_1 <= '0;
		end else if (state_q == st_writeback) begin
			u_prev <= sum_q;
			e_prev_0 <= e_q;
			e_prev_1 <= e_prev_0; // shift history
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// state machine
	////////////////////////////////////////////////////////////////////////////

	assign compute_done = (state_q == st_compute) && (cnt == W_CNT'(`COMP_LATENCY - 1));

	always_comb begin
		state_d = state_q;
		case (state_q)
			st_idle: if (avg_valid && lock_en) state_d = st_compute;
			st_compute: if (compute_done) state_d = st_send;
			st_send: if (out_ready) state_d = st_writeback; // transfer this cycle
			st_writeback: state_d = st_idle;
			default: state_d = st_idle;
		endcase
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			state_q <= st_idle;
			cnt <= '0;
		end else begin
			state_q <= state_d;
			cnt <= (state_q == st_compute && !compute_done) ? cnt + 1'b1 : '0;
		end
	end

endmodule

// File: source/dac_output_stage.sv
`timescale 1ns/1ps
`include "lock_defs.svh"

module dac_output_stage (
	input logic clk_in,
	input logic reset_in,
	input logic signed [`W_SUM-1:0] pid_data, // wide control sum
	input logic pid_valid,
	output logic out_ready, // a credit is available
	input logic dac_credit, // one credit back per pulse
	output logic signed [`W_DAC-1:0] dac_data,
	output logic dac_valid
);

	localparam int W_CRED = $clog2(`DAC_CREDITS + 1);
	localparam logic signed [`W_DAC-1:0] DAC_MAX = {1'b0, {(`W_DAC-1){1'b1}}};
	localparam logic signed [`W_DAC-1:0] DAC_MIN = {1'b1, {(`W_DAC-1){1'b0}}};

	logic signed [`W_SUM-1:0] shifted; // sum scaled toward dac range
	logic [`W_SUM-`W_DAC:0] upper; // sign bits above dac word
	logic fits; // no saturation needed
	logic transfer; // core hands over a word
	logic [W_CRED-1:0] credits; // words the dac can still take

	assign shifted = pid_data >>> `OUT_SHIFT;
	assign upper = shifted[`W_SUM-1:`W_DAC-1];
	assign fits = (&upper) || !(|upper); // all ones or all zeros
	assign transfer = pid_valid && out_ready;
	assign out_ready = (credits != '0);

	////////////////////////////////////////////////////////////////////////////
	// scaled and saturated output word
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (transfer) begin
			dac_data <= fits ? shifted[`W_DAC-1:0] : (shifted[`W_SUM-1] ? DAC_MIN : DAC_MAX);
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			dac_valid <= 1'b0;
		end else begin
			dac_valid <= transfer; // cycle after transfer
		end
	end

	// credit counter, spent at transfer
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			credits <= W_CRED'(`DAC_CREDITS);
		end else if (transfer && !dac_credit) begin
			credits <= credits - 1'b1;
		end else if (dac_credit && !transfer) begin
			credits <= credits + 1'b1;
		end
	end

endmodule

// File: source/lock_top.sv
`timescale 1ns/1ps
`include "lock_defs.svh"

module lock_top (
	input logic clk_in,
	input logic reset_in,
	input logic signed [`W_ADC-1:0] adc_data,
	input logic adc_valid,
	input logic cfg_write,
	input lock_pkg::param_addr_e cfg_addr,
	input logic signed [`W_EP-1:0] cfg_data,
	input logic update_en,
	input logic lock_en,
	input logic dac_credit,
	output logic signed [`W_DAC-1:0] dac_data,
	output logic dac_valid
);

	logic signed [`W_ADC-1:0] avg_data; // filter to core
	logic avg_valid;
	logic signed [`W_EP-1:0] setpoint, p_coef, i_coef, d_coef; // bank to core
	logic signed [`W_SUM-1:0] pid_data; // core to output stage
	logic pid_valid;
	logic out_ready; // back from output stage

	oversample_filter u_filter (
		.clk_in, .reset_in, .adc_data, .adc_valid, .avg_data, .avg_valid
	);

	pid_param_bank u_bank (
		.clk_in, .reset_in, .cfg_write, .cfg_addr, .cfg_data, .update_en,
		.setpoint, .p_coef, .i_coef, .d_coef
	);

	pid_core u_core (
		.clk_in, .reset_in, .lock_en, .avg_data, .avg_valid,
		.setpoint, .p_coef, .i_coef, .d_coef, .out_ready, .pid_data, .pid_valid
	);

	dac_output_stage u_out (
		.clk_in, .reset_in, .pid_data, .pid_valid, .out_ready,
		.dac_credit, .dac_data, .dac_valid
	);

endmodule

// File: tb/lock_chk.sv
`timescale 1ns/1ps
`include "lock_defs.svh"

module lock_chk #(
	parameter int W_CRED = $clog2(`DAC_CREDITS + 1) // same width as the output stage counter
) (
	input logic clk_in,
	input logic reset_in,
	input logic [W_CRED-1:0] credits, // output stage credit counter
	input logic dac_valid,
	input logic dac_credit, // credit pulse from the dac
	input logic pid_valid,
	input logic out_ready,
	input logic signed [`W_SUM-1:0] pid_data
);

	logic [W_CRED-1:0] held; // credits as counted at the dac pins

	// dac side count, words taken and credits given back
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			held <= W_CRED'(`DAC_CREDITS);
		end else begin
			held <= held - W_CRED'(dac_valid) + W_CRED'(dac_credit);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// credit rules
	////////////////////////////////////////////////////////////////////////////

	assert property (@(posedge clk_in) disable iff (reset_in)
		dac_valid |-> held != '0) // word sent only with a credit
		else $error("dac_valid raised while no credit was held");

	assert property (@(posedge clk_in) disable iff (reset_in)
		credits <= W_CRED'(`DAC_CREDITS)) // never more than the reset count
		else $error("credit counter went above its reset value");

	// core handshake, word held while the output stage is full
	assert property (@(posedge clk_in) disable iff (reset_in)
		(pid_valid && !out_ready) |=> (pid_valid && $stable(pid_data)))
		else $error("pid_data changed or pid_valid dropped while out_ready was low");

endmodule

bind dac_output_stage lock_chk u_chk (
	.clk_in, .reset_in, .credits, .dac_valid, .dac_credit,
	.pid_valid, .out_ready, .pid_data
);

// File: tb/lock_monitor.sv
`timescale 1ns/1ps
`include "lock_defs.svh"

module lock_monitor (
	input logic clk_in,
	input logic reset_in,
	input logic signed [`W_ADC-1:0] adc_data,
	input logic adc_valid,
	input logic cfg_write,
	input lock_pkg::param_addr_e cfg_addr,
	input logic signed [`W_EP-1:0] cfg_data,
	input logic update_en,
	input logic lock_en,
	input logic signed [`W_DAC-1:0] dac_data,
	input logic dac_valid
);

	import lock_pkg::*;

	localparam longint SUM_HI = 64'sh7FFF_FFFF_FFFF_FFFF; // wide sum rails
	localparam longint SUM_LO = -SUM_HI - 64'sd1;
	localparam longint DAC_HI = (64'sd1 <<< (`W_DAC - 1)) - 64'sd1; // dac word rails
	localparam longint DAC_LO = -DAC_HI - 64'sd1;

	longint sp, kp, ki, kd; // copy of the register bank
	longint m_e1, m_e2, m_u; // model error history and last sum
	longint grp_sum; // samples of the open group
	int grp_cnt;
	int exp_q[$]; // words still to come out
	int want;
	int checks, errors, test_checks, test_errors;

	// one group through average, velocity pid, rails, shift and saturation
	function automatic int expected_word(input longint sum4);
		longint avg, e, delta, u, w;
		avg = sum4 >>> `OVERSAMPLE_LOG; // floor of the mean
		e = sp - avg;
		delta = (kp + ki + kd) * e + (-kp - (kd <<< 1)) * m_e1 + kd * m_e2;
		u = m_u + delta;
		if (((delta < 0) == (m_u < 0)) && ((u < 0) != (m_u < 0)))
			u = (m_u < 0) ? SUM_LO : SUM_HI; // wrapped, rail by old sign
		m_e2 = m_e1;
		m_e1 = e;
		m_u = u;
		w = u >>> `OUT_SHIFT;
		if (w > DAC_HI) w = DAC_HI;
		else if (w < DAC_LO) w = DAC_LO;
		return int'(w);
	endfunction

	task automatic report_error(input string msg);
		$display("%s (at %0t)", msg, $time);
		errors++;
		test_errors++;
	endtask

	task automatic end_test(input string name);
		$display("test %s: %0d words checked, %0d errors", name, test_checks, test_errors);
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic print_counts();
		$display("total: %0d words checked, %0d errors", checks, errors);
	endtask

	// inputs and outputs all settled at the falling edge
	always @(negedge clk_in) begin
		if (reset_in) begin
			sp = `SETPOINT_INIT; // bank initial values
			kp = `P_COEF_INIT;
			ki = `I_COEF_INIT;
			kd = `D_COEF_INIT;
			m_e1 = 0;
			m_e2 = 0;
			m_u = 0;
			grp_sum = 0;
			grp_cnt = 0;
			exp_q.delete();
		end else begin
			if (!lock_en) begin
				m_e1 = 0; // unlock clears history
				m_e2 = 0;
				m_u = 0;
			end
			if (cfg_write && update_en) begin
				case (cfg_addr)
					addr_setpoint: sp = longint'(cfg_data);
					addr_p: kp = longint'(cfg_data);
					addr_i: ki = longint'(cfg_data);
					default: kd = longint'(cfg_data);
				endcase
			end
			if (adc_valid) begin
				grp_sum += longint'(adc_data);
				grp_cnt++;
				if (grp_cnt == (1 << `OVERSAMPLE_LOG)) begin
					exp_q.push_back(expected_word(grp_sum)); // group closed
					grp_sum = 0;
					grp_cnt = 0;
				end
			end
			if (dac_valid) begin
				if (exp_q.size() == 0) begin
					report_error("dac_valid came with no word expected");
				end else begin
					want = exp_q.pop_front();
					checks++;
					test_checks++;
					if (int'(dac_data) != want) begin
						$display("FAILED at %0t: dac_data expected %0d, got %0d",
							$time, want, dac_data);
						errors++;
						test_errors++;
					end
				end
			end
		end
	end

endmodule

// File: tb/lock_tb.sv
`timescale 1ns/1ps
`include "lock_defs.svh"

module lock_tb;

	import lock_pkg::*;

	logic clk_in;
	logic reset_in;
	logic signed [`W_ADC-1:0] adc_data;
	logic adc_valid;
	logic cfg_write;
	param_addr_e cfg_addr;
	logic signed [`W_EP-1:0] cfg_data;
	logic update_en;
	logic lock_en;
	logic dac_credit;
	logic signed [`W_DAC-1:0] dac_data;
	logic dac_valid;
	logic [15:0] lfsr; // sample source
	bit seen;

	always #5 clk_in = ~clk_in; // 10 ns period

	lock_top uut (.*);

	lock_monitor mon (.*);

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic random_bits(input int n, output int v);
		v = 0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_step(lfsr); // one step per bit
			v = (v << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic tick();
		@(posedge clk_in);
		#1; // drive and sample away from the edge
	endtask

	// one group of samples, base plus centred random spread
	task automatic send_group(input int base, input int bits);
		int r;
		for (int k = 0; k < (1 << `OVERSAMPLE_LOG); k++) begin
			r = 0;
			if (bits > 0) begin
				random_bits(bits, r);
				r -= 1 << (bits - 1);
			end
			adc_data = `W_ADC'(base + r);
			adc_valid = 1'b1;
			tick();
		end
		adc_valid = 1'b0;
	endtask

	task automatic wait_out(input int limit, output bit got);
		got = 1'b0;
		for (int k = 0; k < limit && !got; k++) begin
			tick();
			got = dac_valid;
		end
	endtask

	task automatic expect_out(input string what, input bit give_back);
		bit got;
		wait_out(40, got);
		if (!got) begin
			mon.report_error({"no dac_valid in time for ", what});
		end else if (give_back) begin
			dac_credit = 1'b1; // return the credit
			tick();
			dac_credit = 1'b0;
		end
	endtask

	task automatic write_reg(input param_addr_e a, input int v, input bit en);
		cfg_addr = a;
		cfg_data = `W_EP'(v);
		update_en = en;
		cfg_write = 1'b1;
		tick();
		cfg_write = 1'b0;
		update_en = 1'b0;
	endtask

	initial begin
		#100us; // run limit
		$display("simulation ran past its time limit");
		$display("Done: errors found");
		$finish;
	end

	initial begin
		clk_in = 1'b0;
		reset_in = 1'b1;
		adc_data = '0;
		adc_valid = 1'b0;
		cfg_write = 1'b0;
		cfg_addr = addr_setpoint;
		cfg_data = '0;
		update_en = 1'b0;
		lock_en = 1'b1;
		dac_credit = 1'b0;
		lfsr = 16'd67; // seed
		repeat (5) @(posedge clk_in);
		#1 reset_in = 1'b0;
		tick();

		send_group(400, 0); // zero history, k1 term only
		expect_out("first group", 1'b1);
		mon.end_test("1 first output");

		repeat (6) begin
			send_group(0, 12);
			expect_out("random group", 1'b1);
		end
		mon.end_test("2 random groups");

		write_reg(addr_p, 20, 1'b1);
		write_reg(addr_i, 5, 1'b1);
		write_reg(addr_d, 7, 1'b1);
		write_reg(addr_p, 999, 1'b0); // ignored, update off
		write_reg(addr_setpoint, 500, 1'b0);
		repeat (4) begin
			send_group(0, 12);
			expect_out("group after writes", 1'b1);
		end
		mon.end_test("3 new coefficients");

		send_group(120000, 0); // large negative error
		expect_out("large sample", 1'b1);
		if (dac_data != {1'b1, {(`W_DAC-1){1'b0}}})
			mon.report_error("large positive sample did not reach the low rail");
		send_group(-120000, 0);
		expect_out("large negative sample", 1'b1);
		if (dac_data != {1'b0, {(`W_DAC-1){1'b1}}})
			mon.report_error("large negative sample did not reach the high rail");
		mon.end_test("4 rails");

		repeat (`DAC_CREDITS) begin
			send_group(0, 12);
			expect_out("word within credits", 1'b0);
		end
		send_group(0, 12); // core stalls in send
		wait_out(30, seen);
		if (seen)
			mon.report_error("dac_valid appeared with no credits left");
		dac_credit = 1'b1;
		tick();
		dac_credit = 1'b0;
		expect_out("held word", 1'b1);
		repeat (`DAC_CREDITS - 1) begin
			dac_credit = 1'b1; // refill counter
			tick();
			dac_credit = 1'b0;
		end
		mon.end_test("5 credit back-pressure");

		lock_en = 1'b0;
		repeat (3) tick();
		lock_en = 1'b1;
		tick();
		send_group(250, 0); // history cleared again
		expect_out("group after relock", 1'b1);
		mon.end_test("6 lock enable");

		mon.print_counts();
		if (mon.errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// File: src.f
+incdir+include
source/lock_pkg.sv
source/oversample_filter.sv
source/pid_param_bank.sv
source/pid_core.sv
source/dac_output_stage.sv
source/lock_top.sv
tb/lock_chk.sv
tb/lock_monitor.sv
tb/lock_tb.sv

// File: run.sh
#!/bin/sh
# build and run the lock loop testbench with verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f src.f --top-module lock_tb -o lock_sim &&
./obj_dir/lock_sim | tee /dev/stderr | grep -q "Done: no errors" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
